// ==== rtl/ps2_mouse_pkg.sv ====
`default_nettype none

package ps2_mouse_pkg;

  // ------------------------------
  // line conditioning
  // ------------------------------
  localparam int PS2_SYNC_STAGES = 2;  // flops on each raw PS/2 line
  localparam int PS2_FILTER_LEN  = 4;  // equal samples before the filtered clock moves
  localparam int FILTER_CNT_W    = $clog2(PS2_FILTER_LEN);

  // ------------------------------
  // frame receiver
  // ------------------------------
  localparam int FRAME_TIMEOUT_CYCLES = 2000;  // about 80 us at 25 MHz
  localparam int TIMEOUT_W            = $clog2(FRAME_TIMEOUT_CYCLES);
  localparam int ERR_CNT_W            = 4;     // error counter saturates at all ones

  // ------------------------------
  // mouse report
  // ------------------------------
  localparam int POS_W   = 10;  // absolute cursor counters wrap at 1024
  localparam int DELTA_W = 9;   // sign bit from byte 0 plus the magnitude byte

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    PKT_BYTE0,
    PKT_BYTE1,
    PKT_BYTE2
  } pkt_state_e;

endpackage

`default_nettype wire

// ==== rtl/ps2_line_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_line_sync
(
  input  wire logic clk,
  input  wire logic arst_n,
  input  wire logic ps2_clk,
  input  wire logic ps2_dat,
  output logic      fall_pulse,
  output logic      data_bit
);
  import ps2_mouse_pkg::*;

  logic [PS2_SYNC_STAGES-1:0] clk_sync;  // lsb takes the raw pin
  logic [PS2_SYNC_STAGES-1:0] dat_sync;
  logic [FILTER_CNT_W-1:0]    filt_cnt;
  logic                       clk_filt;
  logic                       clk_s;
  logic                       filt_fall;

  assign clk_s = clk_sync[PS2_SYNC_STAGES-1];

  // the filtered clock is about to drop from high to low in this cycle
  assign filt_fall = clk_filt && !clk_s && (filt_cnt == FILTER_CNT_W'(PS2_FILTER_LEN - 1));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      clk_sync   <= '1;  // both lines idle high on an open-collector bus
      dat_sync   <= '1;
      filt_cnt   <= '0;
      clk_filt   <= 1'b1;
      fall_pulse <= 1'b0;
    end
    else
    begin
      clk_sync   <= {clk_sync[PS2_SYNC_STAGES-2:0], ps2_clk};
      dat_sync   <= {dat_sync[PS2_SYNC_STAGES-2:0], ps2_dat};
      fall_pulse <= filt_fall;
      if (clk_s == clk_filt)
        filt_cnt <= '0;  // any agreeing sample restarts the run
      else if (filt_cnt == FILTER_CNT_W'(PS2_FILTER_LEN - 1))
      begin
        clk_filt <= clk_s;
        filt_cnt <= '0;
      end
      else
        filt_cnt <= filt_cnt + 1'b1;
    end
  end

  // the device changes data while the clock is high, so it is settled here
  always_ff @(posedge clk)
  begin
    if (filt_fall)
      data_bit <= dat_sync[PS2_SYNC_STAGES-1];
  end

  // a filtered edge needs several samples, so two pulses can never touch
  a_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    fall_pulse |=> !fall_pulse);

endmodule

`default_nettype wire

// ==== rtl/ps2_frame_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_frame_rx
(
  input  wire logic                               clk,
  input  wire logic                               arst_n,
  input  wire logic                               fall_pulse,
  input  wire logic                               data_bit,
  output logic                                    byte_valid,
  output logic [7:0]                              byte_data,
  output logic [ps2_mouse_pkg::ERR_CNT_W-1:0]     error_count
);
  import ps2_mouse_pkg::*;

  rx_state_e            state;
  logic [2:0]           bit_cnt;
  logic [7:0]           shift_q;   // data bits arrive lsb first
  logic                 parity;    // running xor, ends at one for a good frame
  logic [TIMEOUT_W-1:0] idle_cnt;  // cycles since the last clock edge in a frame
  logic                 timeout;
  logic                 frame_err;

  // ------------------------------
  // checks
  // ------------------------------
  assign timeout = (state != RX_IDLE) && !fall_pulse &&
                   (idle_cnt == TIMEOUT_W'(FRAME_TIMEOUT_CYCLES - 1));

  // bad start bit, or bad parity or stop bit at the end of the frame
  assign frame_err = fall_pulse &&
                     (((state == RX_IDLE) && data_bit) ||
                      ((state == RX_STOP) && (!data_bit || !parity)));

  assign byte_data = shift_q;  // held stable until the next frame shifts in

  // ------------------------------
  // receive FSM
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      shift_q     <= '0;
      parity      <= 1'b0;
      idle_cnt    <= '0;
      byte_valid  <= 1'b0;
      error_count <= '0;
    end
    else
    begin
      byte_valid <= 1'b0;
      if (fall_pulse || (state == RX_IDLE))
        idle_cnt <= '0;
      else
        idle_cnt <= idle_cnt + 1'b1;
      if (frame_err && (error_count != '1))
        error_count <= error_count + 1'b1;  // saturates rather than wrapping
      if (timeout)
        state <= RX_IDLE;  // stalled frame is dropped quietly
      else if (fall_pulse)
      begin
        case (state)
          RX_IDLE:
          begin
            bit_cnt <= '0;
            parity  <= 1'b0;
            if (!data_bit)
              state <= RX_DATA;
          end
          RX_DATA:
          begin
            shift_q <= {data_bit, shift_q[7:1]};
            parity  <= parity ^ data_bit;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= RX_PARITY;
          end
          RX_PARITY:
          begin
            parity <= parity ^ data_bit;
            state  <= RX_STOP;
          end
          RX_STOP:
          begin
            byte_valid <= data_bit && parity;  // forward only clean frames
            state      <= RX_IDLE;
          end
          default:
            state <= RX_IDLE;
        endcase
      end
    end
  end

  // a byte is only ever released by the stop bit edge
  a_valid_at_stop: assert property (@(posedge clk) disable iff (!arst_n)
    byte_valid |-> ($past(state) == RX_STOP) && $past(fall_pulse));

endmodule

`default_nettype wire

// ==== rtl/mouse_packet_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module mouse_packet_assembler
(
  input  wire logic                                     clk,
  input  wire logic                                     arst_n,
  input  wire logic                                     byte_valid,
  input  wire logic [7:0]                               byte_data,
  output logic                                          packet_valid,
  output logic [2:0]                                    buttons,
  output logic signed [ps2_mouse_pkg::DELTA_W-1:0]      delta_x,
  output logic signed [ps2_mouse_pkg::DELTA_W-1:0]      delta_y
);
  import ps2_mouse_pkg::*;

  pkt_state_e state;
  logic [7:0] status_q;  // byte 0 of the report
  logic [7:0] x_mag_q;   // byte 1 of the report
  logic       take_status;
  logic       take_x;
  logic       take_y;

  // ------------------------------
  // byte routing
  // ------------------------------
  assign take_status = byte_valid && (state == PKT_BYTE0) && byte_data[3];
  assign take_x      = byte_valid && (state == PKT_BYTE1);
  assign take_y      = byte_valid && (state == PKT_BYTE2);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= PKT_BYTE0;
      packet_valid <= 1'b0;
    end
    else
    begin
      packet_valid <= take_y;
      case (state)
        PKT_BYTE0:
          if (take_status)
            state <= PKT_BYTE1;  // a byte without the always-one bit is skipped
        PKT_BYTE1:
          if (take_x)
            state <= PKT_BYTE2;
        PKT_BYTE2:
          if (take_y)
            state <= PKT_BYTE0;
        default:
          state <= PKT_BYTE0;
      endcase
    end
  end

  // ------------------------------
  // report decode
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (take_status)
      status_q <= byte_data;
    if (take_x)
      x_mag_q <= byte_data;
    if (take_y)
    begin
      buttons <= status_q[2:0];
      delta_x <= status_q[6] ? '0 : {status_q[4], x_mag_q};  // overflowed axis moves nothing
      delta_y <= status_q[7] ? '0 : {status_q[5], byte_data};
    end
  end

  // a report only completes on the third byte after a real status byte
  a_pkt_after_byte2: assert property (@(posedge clk) disable iff (!arst_n)
    packet_valid |-> $past(byte_valid) && ($past(state) == PKT_BYTE2) && status_q[3]);

endmodule

`default_nettype wire

// ==== rtl/mouse_position_accum.sv ====
`timescale 1ns/100ps
`default_nettype none

module mouse_position_accum
(
  input  wire logic                                       clk,
  input  wire logic                                       arst_n,
  input  wire logic                                       packet_valid,
  input  wire logic [2:0]                                 buttons_in,
  input  wire logic signed [ps2_mouse_pkg::DELTA_W-1:0]   delta_x,
  input  wire logic signed [ps2_mouse_pkg::DELTA_W-1:0]   delta_y,
  output logic [ps2_mouse_pkg::POS_W-1:0]                 x_pos,
  output logic [ps2_mouse_pkg::POS_W-1:0]                 y_pos,
  output logic [2:0]                                      buttons,
  output logic                                            packet_strobe
);
  import ps2_mouse_pkg::*;

  logic [POS_W-1:0] dx_ext;
  logic [POS_W-1:0] dy_ext;

  // sign bit replicated up to the counter width
  assign dx_ext = {{(POS_W - DELTA_W){delta_x[DELTA_W-1]}}, delta_x};
  assign dy_ext = {{(POS_W - DELTA_W){delta_y[DELTA_W-1]}}, delta_y};

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      x_pos         <= '0;
      y_pos         <= '0;
      buttons       <= '0;
      packet_strobe <= 1'b0;
    end
    else
    begin
      packet_strobe <= packet_valid;  // marks the cycle the new values appear
      if (packet_valid)
      begin
        x_pos   <= x_pos + dx_ext;  // wraps modulo 2^POS_W
        y_pos   <= y_pos + dy_ext;
        buttons <= buttons_in;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ps2_mouse_board.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_mouse_board
(
  input  wire logic                                  clk,
  input  wire logic                                  arst_n,
  input  wire logic                                  ps2_clk,
  input  wire logic                                  ps2_dat,
  output logic [ps2_mouse_pkg::POS_W-1:0]            x_pos,
  output logic [ps2_mouse_pkg::POS_W-1:0]            y_pos,
  output logic [2:0]                                 buttons,
  output logic                                       packet_strobe,
  output logic [ps2_mouse_pkg::ERR_CNT_W-1:0]        error_count,
  output logic [7:0]                                 led
);
  import ps2_mouse_pkg::*;

  logic                      fall_pulse;
  logic                      data_bit;
  logic                      byte_valid;
  logic [7:0]                byte_data;
  logic                      packet_valid;
  logic [2:0]                pkt_buttons;
  logic signed [DELTA_W-1:0] delta_x;
  logic signed [DELTA_W-1:0] delta_y;

  // ------------------------------
  // receive chain
  // ------------------------------
  ps2_line_sync u_line_sync (
    .clk        (clk),
    .arst_n     (arst_n),
    .ps2_clk    (ps2_clk),
    .ps2_dat    (ps2_dat),
    .fall_pulse (fall_pulse),
    .data_bit   (data_bit)
  );

  ps2_frame_rx u_frame_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .fall_pulse  (fall_pulse),
    .data_bit    (data_bit),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .error_count (error_count)
  );

  mouse_packet_assembler u_packet (
    .clk          (clk),
    .arst_n       (arst_n),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .packet_valid (packet_valid),
    .buttons      (pkt_buttons),
    .delta_x      (delta_x),
    .delta_y      (delta_y)
  );

  mouse_position_accum u_accum (
    .clk           (clk),
    .arst_n        (arst_n),
    .packet_valid  (packet_valid),
    .buttons_in    (pkt_buttons),
    .delta_x       (delta_x),
    .delta_y       (delta_y),
    .x_pos         (x_pos),
    .y_pos         (y_pos),
    .buttons       (buttons),
    .packet_strobe (packet_strobe)
  );

  // low position bits flicker visibly as the mouse moves
  assign led = {y_pos[1:0], x_pos[1:0], buttons, |error_count};

endmodule

`default_nettype wire

// ==== verification/ps2_mouse_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_mouse_tb;
  import ps2_mouse_pkg::*;

  localparam int HALF_CYCLES  = 20;  // system cycles per PS/2 clock half period
  localparam int PKT_BUDGET   = 40;
  localparam int BITS_PER_PKT = 33;
  localparam int CYCLE_LIMIT  = PKT_BUDGET * BITS_PER_PKT * 2 * HALF_CYCLES +
                                FRAME_TIMEOUT_CYCLES + 10000;
  localparam int POS_MASK     = (1 << POS_W) - 1;

  logic                 clk;
  logic                 arst_n;
  logic                 ps2_clk;
  logic                 ps2_dat;
  logic [POS_W-1:0]     x_pos;
  logic [POS_W-1:0]     y_pos;
  logic [2:0]           buttons;
  logic                 packet_strobe;
  logic [ERR_CNT_W-1:0] error_count;
  logic [7:0]           led;

  int         exp_x = 0;  // reference cursor model
  int         exp_y = 0;
  logic [2:0] exp_btn = '0;
  int         exp_err = 0;
  int         strobe_count = 0;
  int         cycle_count = 0;
  integer     seed;

  ps2_mouse_board dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .ps2_clk       (ps2_clk),
    .ps2_dat       (ps2_dat),
    .x_pos         (x_pos),
    .y_pos         (y_pos),
    .buttons       (buttons),
    .packet_strobe (packet_strobe),
    .error_count   (error_count),
    .led           (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk)
    if (packet_strobe)
      strobe_count <= strobe_count + 1;  // the strobe can come before the device finishes

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ------------------------------
  // checking
  // ------------------------------
  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected)
    begin
      $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_outputs();
    check(x_pos, exp_x, "x_pos");
    check(y_pos, exp_y, "y_pos");
    check(buttons, exp_btn, "buttons");
    check(error_count, exp_err, "error_count");
    check(led, {exp_y[1:0], exp_x[1:0], exp_btn, exp_err != 0}, "led");
  endtask

  // ------------------------------
  // PS/2 device model
  // ------------------------------
  task automatic drive_bit(input logic b);
    ps2_dat <= b;  // data moves while the clock is high
    repeat (HALF_CYCLES) @(posedge clk);
    ps2_clk <= 1'b0;
    repeat (HALF_CYCLES) @(posedge clk);
    ps2_clk <= 1'b1;
  endtask

  task automatic send_frame(input logic [10:0] frame, input int nbits);
    int i;
    @(posedge clk);
    for (i = 0; i < nbits; i++)
      drive_bit(frame[i]);
    ps2_dat <= 1'b1;
    repeat (2 * HALF_CYCLES) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] data, input logic bad_parity,
                           input logic bad_stop);
    logic par;
    par = ~^data ^ bad_parity;  // odd parity across data and parity bit
    send_frame({~bad_stop, par, data, 1'b0}, 11);
  endtask

  task automatic wait_for_strobe(input int start);
    while (strobe_count == start)
      @(posedge clk);
    @(negedge clk);
  endtask

  task automatic send_packet(input logic [2:0] btn, input int dx, input int dy,
                             input logic x_ovf, input logic y_ovf);
    logic [8:0] dx9;
    logic [8:0] dy9;
    int         start;
    dx9   = dx[8:0];
    dy9   = dy[8:0];
    start = strobe_count;
    send_byte({y_ovf, x_ovf, dy9[8], dx9[8], 1'b1, btn}, 1'b0, 1'b0);
    send_byte(dx9[7:0], 1'b0, 1'b0);
    send_byte(dy9[7:0], 1'b0, 1'b0);
    if (!x_ovf)
      exp_x = (exp_x + dx) & POS_MASK;
    if (!y_ovf)
      exp_y = (exp_y + dy) & POS_MASK;
    exp_btn = btn;
    wait_for_strobe(start);
    check(strobe_count, start + 1, "one strobe per packet");
    check_outputs();
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_values_test();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_outputs();
  endtask

  task automatic motion_test();
    int i;
    send_packet(3'b001, 25, 40, 1'b0, 1'b0);
    send_packet(3'b010, -100, -7, 1'b0, 1'b0);
    send_packet(3'b100, 255, -256, 1'b0, 1'b0);
    for (i = 0; i < 8; i++)
      send_packet(i[2:0], $random(seed) % 256, $random(seed) % 256, 1'b0, 1'b0);
    for (i = 0; i < 5; i++)
      send_packet(3'b000, 255, -256, 1'b0, 1'b0);  // forces both counters to wrap
  endtask

  task automatic overflow_test();
    send_packet(3'b011, 77, -30, 1'b1, 1'b0);
    send_packet(3'b000, -50, 99, 1'b0, 1'b1);
  endtask

  task automatic framing_error_test();
    int start;
    start = strobe_count;
    send_byte(8'h0a, 1'b0, 1'b0);  // opens a report, so a leaked byte would complete it
    send_byte(8'h08, 1'b1, 1'b0);
    send_byte(8'h09, 1'b0, 1'b1);
    exp_err = exp_err + 2;
    @(negedge clk);
    check(strobe_count, start, "no packet from bad frames");
    check(error_count, exp_err, "error_count after bad frames");
    send_byte(8'h05, 1'b0, 1'b0);  // x and y bytes close the open report
    send_byte(8'h03, 1'b0, 1'b0);
    exp_x   = (exp_x + 5) & POS_MASK;
    exp_y   = (exp_y + 3) & POS_MASK;
    exp_btn = 3'b010;
    wait_for_strobe(start);
    check(strobe_count, start + 1, "one strobe for the resumed report");
    check_outputs();
    send_packet(3'b101, -12, 33, 1'b0, 1'b0);
  endtask

  task automatic stray_byte_test();
    send_byte(8'h45, 1'b0, 1'b0);  // bit 3 clear, not a status byte
    send_packet(3'b110, 60, -60, 1'b0, 1'b0);
  endtask

  task automatic abandoned_frame_test();
    send_frame({1'b1, 1'b0, 8'h18, 1'b0}, 5);
    repeat (FRAME_TIMEOUT_CYCLES + 500) @(posedge clk);
    @(negedge clk);
    check(error_count, exp_err, "error_count after abandoned frame");
    send_packet(3'b001, 7, 9, 1'b0, 1'b0);
  endtask

  initial
  begin
    seed    = 32'he3c634d6;
    arst_n  = 1'b0;
    ps2_clk = 1'b1;  // idle bus
    ps2_dat = 1'b1;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    reset_values_test();
    motion_test();
    overflow_test();
    framing_error_test();
    stray_byte_test();
    abandoned_frame_test();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ps2_mouse.f ====
rtl/ps2_mouse_pkg.sv
rtl/ps2_line_sync.sv
rtl/ps2_frame_rx.sv
rtl/mouse_packet_assembler.sv
rtl/mouse_position_accum.sv
rtl/ps2_mouse_board.sv
verification/ps2_mouse_tb.sv
